// ==== source/fifo_config.svh ====
// --------------------------------------
// fifo controller configuration
// depth and static flag thresholds
// --------------------------------------
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// address width, log2 of the depth
`define FIFO_AW 4

// number of words, always a power of two
`define FIFO_DEPTH (1 << `FIFO_AW)

// almost full asserts at this word count and above
`define FIFO_AFULL_VAL 12

// almost empty asserts at this word count and below
`define FIFO_AEMPTY_VAL 4

`endif

// ==== source/fifo_ptr_pkg.sv ====
// --------------------------------------
// fifo pointer types
// wrapping pointers and memory addresses
// --------------------------------------
`default_nettype none

`include "fifo_config.svh"

package fifo_ptr_pkg;

   // --------------------------------------
   // pointer
   // --------------------------------------
   // one bit wider than the address
   // msb tells a full fifo from an empty one
   typedef logic [`FIFO_AW:0] ptr_t;

   // --------------------------------------
   // address
   // --------------------------------------
   // low pointer bits, no wrap counter needed
   typedef logic [`FIFO_AW-1:0] addr_t;

endpackage

`default_nettype wire

// ==== source/fifo_level_pkg.sv ====
// --------------------------------------
// fifo level types
// word counts seen by the two sides
// --------------------------------------
`default_nettype none

`include "fifo_config.svh"

package fifo_level_pkg;

   // --------------------------------------
   // word count
   // --------------------------------------
   // holds 0 up to the full depth
   // so it needs one bit more than the address
   typedef logic [`FIFO_AW:0] cnt_t;

   // same width as a pointer difference,
   // which wraps the same way

endpackage

`default_nettype wire

// ==== source/fifo_wr_side.sv ====
// --------------------------------------
// fifo write side
// write pointer, address, ack, overflow
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_config.svh"

module fifo_wr_side (
   // clock and async reset
   input  logic                pos_clk,
   input  logic                aresetn,
   // write strobe from outside
   input  logic                we_i,
   // registered full flag fed back
   input  logic                full_i,
   // accepted write, to flags and memory
   output logic                wr_acc_o,
   output fifo_ptr_pkg::ptr_t  wptr_o,
   output fifo_ptr_pkg::addr_t memwaddr_o,
   // handshake and error strobes
   output logic                wack_o,
   output logic                overflow_o
);

   import fifo_ptr_pkg::*;

   // registered write pointer
   ptr_t wptr_q;

   // --------------------------------------
   // write gating
   // --------------------------------------
   // no back-pressure: a write while full is dropped
   assign wr_acc_o = we_i & ~full_i;

   // --------------------------------------
   // write pointer
   // --------------------------------------
   // wraps through 2*depth, extra msb toggles per lap
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr_q <= '0;
      end else if (wr_acc_o) begin
         wptr_q <= wptr_q + ptr_t'(1);
      end
   end

   assign wptr_o = wptr_q;

   // address is the pointer before the increment
   assign memwaddr_o = wptr_q[`FIFO_AW-1:0];

   // --------------------------------------
   // ack and overflow
   // --------------------------------------
   // both one cycle after the request
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         wack_o     <= wr_acc_o;
         // refused write
         overflow_o <= we_i & full_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/fifo_rd_side.sv ====
// --------------------------------------
// fifo read side
// read pointer, address, dvld, underflow
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_config.svh"

module fifo_rd_side (
   // clock and async reset
   input  logic                pos_clk,
   input  logic                aresetn,
   // read strobe from outside
   input  logic                re_i,
   // registered empty flag fed back
   input  logic                empty_i,
   // accepted read, to flags and memory
   output logic                rd_acc_o,
   output fifo_ptr_pkg::ptr_t  rptr_o,
   output fifo_ptr_pkg::addr_t memraddr_o,
   // data valid and error strobe
   output logic                dvld_o,
   output logic                underflow_o
);

   import fifo_ptr_pkg::*;

   // registered read pointer
   ptr_t rptr_q;

   // --------------------------------------
   // read gating
   // --------------------------------------
   // a read while empty is dropped and flagged
   assign rd_acc_o = re_i & ~empty_i;

   // --------------------------------------
   // read pointer
   // --------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rptr_q <= '0;
      end else if (rd_acc_o) begin
         rptr_q <= rptr_q + ptr_t'(1);
      end
   end

   assign rptr_o = rptr_q;

   // memory sees the current pointer in the same cycle
   assign memraddr_o = rptr_q[`FIFO_AW-1:0];

   // --------------------------------------
   // data valid and underflow
   // --------------------------------------
   // one register stage, data valid matches memory read latency
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o      <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         dvld_o      <= rd_acc_o;
         // refused read
         underflow_o <= re_i & empty_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/fifo_level_flags.sv ====
// --------------------------------------
// fifo level and flags
// word counts and status from the pointers
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_config.svh"

module fifo_level_flags (
   // clock and async reset
   input  logic                 pos_clk,
   input  logic                 aresetn,
   // accepted accesses this cycle
   input  logic                 wr_acc_i,
   input  logic                 rd_acc_i,
   // registered pointers
   input  fifo_ptr_pkg::ptr_t   wptr_i,
   input  fifo_ptr_pkg::ptr_t   rptr_i,
   // write side status
   output fifo_level_pkg::cnt_t wrcnt_o,
   output logic                 full_o,
   output logic                 afull_o,
   // read side status
   output fifo_level_pkg::cnt_t rdcnt_o,
   output logic                 empty_o,
   output logic                 aempty_o
);

   import fifo_ptr_pkg::*;
   import fifo_level_pkg::*;

   // thresholds as counts
   localparam cnt_t full_lvl   = cnt_t'(`FIFO_DEPTH);
   localparam cnt_t afull_lvl  = cnt_t'(`FIFO_AFULL_VAL);
   localparam cnt_t aempty_lvl = cnt_t'(`FIFO_AEMPTY_VAL);

   // pointers with this cycle's access added
   ptr_t wptr_cmb;
   ptr_t rptr_cmb;
   // the two views of the level
   cnt_t wdiff;
   cnt_t rdiff;

   // --------------------------------------
   // pointer differences
   // --------------------------------------
   assign wptr_cmb = wptr_i + ptr_t'(wr_acc_i);
   assign rptr_cmb = rptr_i + ptr_t'(rd_acc_i);

   // write view counts the new write, ignores the read
   // so full can lag a read by one cycle
   assign wdiff = cnt_t'(wptr_cmb - rptr_i);

   // read view counts the new read, ignores the write
   // so empty can lag a write by one cycle
   assign rdiff = cnt_t'(wptr_i - rptr_cmb);

   // --------------------------------------
   // write side flags
   // --------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wrcnt_o <= '0;
         full_o  <= 1'b0;
         afull_o <= 1'b0;
      end else begin
         wrcnt_o <= wdiff;
         // every word in use
         full_o  <= (wdiff == full_lvl);
         // static threshold, no hysteresis
         afull_o <= (wdiff >= afull_lvl);
      end
   end

   // --------------------------------------
   // read side flags
   // --------------------------------------
   // empty after reset
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rdcnt_o  <= '0;
         empty_o  <= 1'b1;
         aempty_o <= 1'b1;
      end else begin
         rdcnt_o  <= rdiff;
         empty_o  <= (rdiff == '0);
         aempty_o <= (rdiff <= aempty_lvl);
      end
   end

endmodule

`default_nettype wire

// ==== source/fifo_sync_ctrl.sv ====
// --------------------------------------
// synchronous fifo controller
// pointers and flags for an external memory
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fifo_sync_ctrl (
   // clock and async reset
   input  logic                 pos_clk,
   input  logic                 aresetn,
   // single-cycle access strobes
   input  logic                 we_i,
   input  logic                 re_i,
   // write side status
   output logic                 full_o,
   output logic                 afull_o,
   output fifo_level_pkg::cnt_t wrcnt_o,
   // read side status
   output logic                 empty_o,
   output logic                 aempty_o,
   output fifo_level_pkg::cnt_t rdcnt_o,
   // handshake and error strobes
   output logic                 wack_o,
   output logic                 dvld_o,
   output logic                 overflow_o,
   output logic                 underflow_o,
   // external memory port
   output logic                 memwe_o,
   output logic                 memre_o,
   output fifo_ptr_pkg::addr_t  memwaddr_o,
   output fifo_ptr_pkg::addr_t  memraddr_o
);

   import fifo_ptr_pkg::*;

   // accepted accesses
   logic wr_acc;
   logic rd_acc;
   // registered pointers to the flag block
   ptr_t wptr;
   ptr_t rptr;

   // --------------------------------------
   // write side
   // --------------------------------------
   // full comes back from the flag block
   fifo_wr_side i_fifo_wr_side (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .full_i     (full_o),
      .wr_acc_o   (wr_acc),
      .wptr_o     (wptr),
      .memwaddr_o (memwaddr_o),
      .wack_o     (wack_o),
      .overflow_o (overflow_o)
   );

   // --------------------------------------
   // read side
   // --------------------------------------
   fifo_rd_side i_fifo_rd_side (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .empty_i     (empty_o),
      .rd_acc_o    (rd_acc),
      .rptr_o      (rptr),
      .memraddr_o  (memraddr_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   // --------------------------------------
   // counts and flags
   // --------------------------------------
   fifo_level_flags i_fifo_level_flags (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .wr_acc_i (wr_acc),
      .rd_acc_i (rd_acc),
      .wptr_i   (wptr),
      .rptr_i   (rptr),
      .wrcnt_o  (wrcnt_o),
      .full_o   (full_o),
      .afull_o  (afull_o),
      .rdcnt_o  (rdcnt_o),
      .empty_o  (empty_o),
      .aempty_o (aempty_o)
   );

   // memory enables are the accepted strobes
   assign memwe_o = wr_acc;
   assign memre_o = rd_acc;

endmodule

`default_nettype wire

// ==== test/fifo_sync_ctrl_assert.sv ====
// --------------------------------------
// fifo controller checker
// occupancy model and concurrent assertions
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fifo_config.svh"

module fifo_sync_ctrl_assert (
   input logic                 pos_clk,
   input logic                 aresetn,
   input logic                 we_i,
   input logic                 re_i,
   input logic                 full_o,
   input logic                 afull_o,
   input fifo_level_pkg::cnt_t wrcnt_o,
   input logic                 empty_o,
   input logic                 aempty_o,
   input fifo_level_pkg::cnt_t rdcnt_o,
   input logic                 wack_o,
   input logic                 dvld_o,
   input logic                 overflow_o,
   input logic                 underflow_o,
   input logic                 memwe_o,
   input logic                 memre_o,
   input fifo_ptr_pkg::addr_t  memwaddr_o,
   input fifo_ptr_pkg::addr_t  memraddr_o
);

   import fifo_ptr_pkg::*;
   import fifo_level_pkg::*;

   // read by the testbench after each test
   int fail_count = 0;

   // accesses the model accepts, gated by the registered flags
   logic acc_w;
   logic acc_r;
   // words really stored
   int   occ;
   // expected memory addresses
   int   waddr_m;
   int   raddr_m;
   // expected registered outputs
   int   wrcnt_m;
   int   rdcnt_m;
   logic [3:0] flags_m;
   logic [3:0] strobes_m;

   assign acc_w = we_i && !full_o;
   assign acc_r = re_i && !empty_o;

   // --------------------------------------
   // reference model
   // --------------------------------------
   // write view adds the new write, read view takes off the new read
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         occ       <= 0;
         waddr_m   <= 0;
         raddr_m   <= 0;
         wrcnt_m   <= 0;
         rdcnt_m   <= 0;
         flags_m   <= 4'b0011;
         strobes_m <= 4'b0000;
      end else begin
         occ        <= occ + int'(acc_w) - int'(acc_r);
         waddr_m    <= (waddr_m + int'(acc_w)) % `FIFO_DEPTH;
         raddr_m    <= (raddr_m + int'(acc_r)) % `FIFO_DEPTH;
         wrcnt_m    <= occ + int'(acc_w);
         rdcnt_m    <= occ - int'(acc_r);
         // full, afull, empty, aempty
         flags_m[3] <= (occ + int'(acc_w)) == `FIFO_DEPTH;
         flags_m[2] <= (occ + int'(acc_w)) >= `FIFO_AFULL_VAL;
         flags_m[1] <= (occ - int'(acc_r)) == 0;
         flags_m[0] <= (occ - int'(acc_r)) <= `FIFO_AEMPTY_VAL;
         // wack, dvld, overflow, underflow
         strobes_m  <= {acc_w, acc_r, we_i && full_o, re_i && empty_o};
      end
   end

   // --------------------------------------
   // checks
   // --------------------------------------
   // reset values, sampled away from the active edge
   a_reset_flags : assert property (@(negedge pos_clk) !aresetn |->
         {full_o, afull_o, empty_o, aempty_o} == 4'b0011)
      else begin
         $error("[ERROR] %0t {full_o,afull_o,empty_o,aempty_o} got %b expected 0011",
                $time, $sampled({full_o, afull_o, empty_o, aempty_o}));
         fail_count++;
      end

   a_reset_strobes : assert property (@(negedge pos_clk) !aresetn |->
         {wack_o, dvld_o, overflow_o, underflow_o} == 4'b0000)
      else begin
         $error("[ERROR] %0t {wack_o,dvld_o,overflow_o,underflow_o} got %b expected 0000",
                $time, $sampled({wack_o, dvld_o, overflow_o, underflow_o}));
         fail_count++;
      end

   a_reset_mem : assert property (@(negedge pos_clk) !aresetn |->
         {memwe_o, memre_o, memwaddr_o, memraddr_o} == '0)
      else begin
         $error("[ERROR] %0t {memwe_o,memre_o,memwaddr_o,memraddr_o} got %h expected 0",
                $time, $sampled({memwe_o, memre_o, memwaddr_o, memraddr_o}));
         fail_count++;
      end

   a_reset_cnt : assert property (@(negedge pos_clk) !aresetn |->
         {wrcnt_o, rdcnt_o} == '0)
      else begin
         $error("[ERROR] %0t {wrcnt_o,rdcnt_o} got %h expected 0",
                $time, $sampled({wrcnt_o, rdcnt_o}));
         fail_count++;
      end

   a_wrcnt : assert property (@(posedge pos_clk) disable iff (!aresetn)
         wrcnt_o == cnt_t'(wrcnt_m))
      else begin
         $error("[ERROR] %0t wrcnt_o got %0d expected %0d",
                $time, $sampled(wrcnt_o), $sampled(wrcnt_m));
         fail_count++;
      end

   a_rdcnt : assert property (@(posedge pos_clk) disable iff (!aresetn)
         rdcnt_o == cnt_t'(rdcnt_m))
      else begin
         $error("[ERROR] %0t rdcnt_o got %0d expected %0d",
                $time, $sampled(rdcnt_o), $sampled(rdcnt_m));
         fail_count++;
      end

   a_flags : assert property (@(posedge pos_clk) disable iff (!aresetn)
         {full_o, afull_o, empty_o, aempty_o} == flags_m)
      else begin
         $error("[ERROR] %0t {full_o,afull_o,empty_o,aempty_o} got %b expected %b",
                $time, $sampled({full_o, afull_o, empty_o, aempty_o}), $sampled(flags_m));
         fail_count++;
      end

   // one cycle after the request
   a_strobes : assert property (@(posedge pos_clk) disable iff (!aresetn)
         {wack_o, dvld_o, overflow_o, underflow_o} == strobes_m)
      else begin
         $error("[ERROR] %0t {wack_o,dvld_o,overflow_o,underflow_o} got %b expected %b",
                $time, $sampled({wack_o, dvld_o, overflow_o, underflow_o}),
                $sampled(strobes_m));
         fail_count++;
      end

   // memory port in the same cycle, address before the increment
   a_wport : assert property (@(posedge pos_clk) disable iff (!aresetn)
         {memwe_o, memwaddr_o} == {acc_w, addr_t'(waddr_m)})
      else begin
         $error("[ERROR] %0t {memwe_o,memwaddr_o} got %h expected %h",
                $time, $sampled({memwe_o, memwaddr_o}), $sampled({acc_w, addr_t'(waddr_m)}));
         fail_count++;
      end

   a_rport : assert property (@(posedge pos_clk) disable iff (!aresetn)
         {memre_o, memraddr_o} == {acc_r, addr_t'(raddr_m)})
      else begin
         $error("[ERROR] %0t {memre_o,memraddr_o} got %h expected %h",
                $time, $sampled({memre_o, memraddr_o}), $sampled({acc_r, addr_t'(raddr_m)}));
         fail_count++;
      end

endmodule

bind fifo_sync_ctrl fifo_sync_ctrl_assert i_fifo_sync_ctrl_assert (.*);

`default_nettype wire

// ==== test/tb_fifo_sync_ctrl.sv ====
// --------------------------------------
// fifo controller testbench
// directed and random strobes, checks bound in
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_fifo_sync_ctrl;

   import fifo_ptr_pkg::*;
   import fifo_level_pkg::*;

   // reset 3, directed about 95, random 300, plus report gaps
   localparam int est_cycles     = 400;
   // generous margin on top of the estimate
   localparam int timeout_cycles = 2 * est_cycles + 200;

   // dut inputs
   logic pos_clk;
   logic aresetn;
   logic we_i;
   logic re_i;
   // dut outputs
   logic full_o;
   logic afull_o;
   cnt_t wrcnt_o;
   logic empty_o;
   logic aempty_o;
   cnt_t rdcnt_o;
   logic wack_o;
   logic dvld_o;
   logic overflow_o;
   logic underflow_o;
   logic memwe_o;
   logic memre_o;
   addr_t memwaddr_o;
   addr_t memraddr_o;

   // bookkeeping
   int cycle_cnt = 0;
   int tests_passed;
   int tests_failed;
   int fails_before;
   int seed_init;

   fifo_sync_ctrl i_fifo_sync_ctrl (.*);

   // --------------------------------------
   // clock and watchdog
   // --------------------------------------
   initial begin
      pos_clk = 1'b0;
      forever #50 pos_clk = ~pos_clk;
   end

   always @(posedge pos_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // --------------------------------------
   // stimulus helpers
   // --------------------------------------
   // inputs change on the falling edge only
   task automatic drive_cycle(input logic we, input logic re);
      @(negedge pos_clk);
      we_i = we;
      re_i = re;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0);
   endtask

   // reads until the empty flag comes up
   task automatic drain_to_empty;
      while (!empty_o) drive_cycle(1'b0, 1'b1);
      we_i = 1'b0;
      re_i = 1'b0;
   endtask

   task automatic report_test(input string name);
      int now_fails;
      // let the last responses reach the checks
      idle_cycles(2);
      now_fails = i_fifo_sync_ctrl.i_fifo_sync_ctrl_assert.fail_count;
      if (now_fails == fails_before) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d assertion failures", name, now_fails - fails_before);
      end
      fails_before = now_fails;
   endtask

   // --------------------------------------
   // test sequence
   // --------------------------------------
   initial begin
      seed_init    = $urandom(32'hb0499f84);
      we_i         = 1'b0;
      re_i         = 1'b0;
      aresetn      = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      fails_before = 0;

      repeat (3) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn = 1'b1;
      report_test("reset state");

      // sixteen accepted, four refused
      repeat (20) drive_cycle(1'b1, 1'b0);
      report_test("fill with overflow");

      // sixteen reads, four underflows, then a short round past the wrap
      repeat (20) drive_cycle(1'b0, 1'b1);
      repeat (8) drive_cycle(1'b1, 1'b0);
      repeat (8) drive_cycle(1'b0, 1'b1);
      report_test("drain with underflow");

      // both strobes at a middle level
      repeat (8) drive_cycle(1'b1, 1'b0);
      repeat (6) drive_cycle(1'b1, 1'b1);
      drain_to_empty();
      report_test("simultaneous access");

      repeat (300) drive_cycle(1'($urandom % 2), 1'($urandom % 2));
      report_test("random traffic");

      $display("tests passed %0d, failed %0d, assertion failures %0d",
               tests_passed, tests_failed, fails_before);
      if (tests_failed == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/fifo_ptr_pkg.sv
source/fifo_level_pkg.sv
source/fifo_wr_side.sv
source/fifo_rd_side.sv
source/fifo_level_flags.sv
source/fifo_sync_ctrl.sv
test/fifo_sync_ctrl_assert.sv
test/tb_fifo_sync_ctrl.sv
